// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int word_size = 16;

    typedef logic [word_size-1:0] word_t;
    typedef logic [1:0]           reg_idx_t;   // Four registers

    // Instruction field positions
    localparam int opcode_hi = 15;
    localparam int opcode_lo = 12;
    localparam int rs_hi     = 11;
    localparam int rs_lo     = 10;
    localparam int rt_hi     = 9;
    localparam int rt_lo     = 8;
    localparam int rd_hi     = 7;
    localparam int rd_lo     = 6;
    localparam int func_hi   = 5;
    localparam int func_lo   = 0;
    localparam int imm_hi    = 7;
    localparam int imm_lo    = 0;
    localparam int target_hi = 11;   // Low bits of the PC on jmp and jal
    localparam int target_lo = 0;

    // Return address register for jal and jrl
    localparam reg_idx_t link_reg = 2'd2;

    typedef enum logic [3:0] {
        op_bne   = 4'd0,
        op_beq   = 4'd1,
        op_bgz   = 4'd2,
        op_blz   = 4'd3,
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_jmp   = 4'd9,
        op_jal   = 4'd10,
        op_rtype = 4'd15
    } opcode_e;

    // R-type function codes, ALU ops occupy 0 to 7
    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_not = 6'd4,
        fn_tcp = 6'd5,
        fn_shl = 6'd6,
        fn_shr = 6'd7,
        fn_jpr = 6'd25,
        fn_jrl = 6'd26,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } func_e;

endpackage

`default_nettype wire

// File: common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;
    import isa_pkg::*;

    // Bit 10 down to bit 0, grouped by the stage that consumes each field
    typedef struct packed {
        logic reg_dst;      // Decode
        logic is_jump_i;    // Execute
        logic is_jump_r;
        logic is_alu;
        logic alu_src;
        logic is_branch;    // Memory
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;   // Writeback
        logic reg_write;
        logic wwd;
    } ctrl_word_t;

    // One-hot state encoding
    typedef enum logic [5:0] {
        s_fetch     = 6'b000001,
        s_decode    = 6'b000010,
        s_execute   = 6'b000100,
        s_mem       = 6'b001000,
        s_writeback = 6'b010000,
        s_halted    = 6'b100000
    } cpu_state_e;

    // jal and jrl write the return address
    function automatic logic is_link(input ctrl_word_t c);
        return c.reg_write & (c.is_jump_i | c.is_jump_r);
    endfunction

    function automatic reg_idx_t dest_reg(input ctrl_word_t c, input reg_idx_t rt,
                                          input reg_idx_t rd);
        if (is_link(c))
            return link_reg;
        return c.reg_dst ? rd : rt;
    endfunction

endpackage

`default_nettype wire

// File: control/control.sv
`timescale 1ns/10ps
`default_nettype none

module control import isa_pkg::*, ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       decode_en,
    input  word_t      instr,
    output ctrl_word_t ctrl,
    output logic       halt_req
);

    opcode_e    opcode;
    logic [5:0] func_raw;
    ctrl_word_t dec_ctrl;
    logic       dec_halt;

    assign opcode   = opcode_e'(instr[opcode_hi:opcode_lo]);
    assign func_raw = instr[func_hi:func_lo];

    always_comb begin
        dec_ctrl = '0;   // Undefined codes fall through as a no-op
        dec_halt = 1'b0;
        case (opcode)
            op_rtype: begin
                if (func_raw[5:3] == 3'b000) begin   // ALU functions 0 to 7
                    dec_ctrl.reg_dst   = 1'b1;
                    dec_ctrl.is_alu    = 1'b1;
                    dec_ctrl.reg_write = 1'b1;
                end else begin
                    case (func_e'(func_raw))
                        fn_wwd: dec_ctrl.wwd = 1'b1;
                        fn_jpr: dec_ctrl.is_jump_r = 1'b1;
                        fn_jrl: begin
                            dec_ctrl.is_jump_r = 1'b1;
                            dec_ctrl.reg_write = 1'b1;
                        end
                        fn_hlt: dec_halt = 1'b1;   // Control word stays zero
                        default: dec_ctrl = '0;
                    endcase
                end
            end
            op_adi, op_ori, op_lhi: begin
                dec_ctrl.alu_src   = 1'b1;
                dec_ctrl.reg_write = 1'b1;
            end
            op_lwd: begin
                dec_ctrl.alu_src    = 1'b1;
                dec_ctrl.mem_read   = 1'b1;
                dec_ctrl.mem_to_reg = 1'b1;
                dec_ctrl.reg_write  = 1'b1;
            end
            op_swd: begin
                dec_ctrl.alu_src   = 1'b1;
                dec_ctrl.mem_write = 1'b1;
            end
            op_bne, op_beq, op_bgz, op_blz: dec_ctrl.is_branch = 1'b1;
            op_jmp: dec_ctrl.is_jump_i = 1'b1;
            op_jal: begin
                dec_ctrl.is_jump_i = 1'b1;
                dec_ctrl.reg_write = 1'b1;
            end
            default: dec_ctrl = '0;
        endcase
    end

    // Control word holds until the next decode, halt request is a single pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl     <= '0;
            halt_req <= 1'b0;
        end else if (decode_en) begin
            ctrl     <= dec_ctrl;
            halt_req <= dec_halt;
        end else begin
            halt_req <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: control/cpu_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_fsm import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  logic       halt_req,
    input  logic       branch_taken,
    output cpu_state_e state,
    output logic       ir_load,
    output logic       decode_en,
    output logic       pc_update,
    output logic       mem_en,
    output logic       wb_en,
    output logic       retire,
    output logic       is_halted
);

    cpu_state_e next_state;
    logic       needs_mem;
    logic       needs_wb;
    logic       last_state;   // Final state of a normal instruction

    assign needs_mem = ctrl.mem_read | ctrl.mem_write;
    assign needs_wb  = ctrl.reg_write | ctrl.wwd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= s_fetch;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        last_state = 1'b0;
        case (state)
            s_fetch:  next_state = s_decode;
            s_decode: next_state = s_execute;
            s_execute: begin
                if (halt_req) begin
                    next_state = s_halted;
                end else if (needs_mem) begin
                    next_state = s_mem;
                end else if (needs_wb) begin
                    next_state = s_writeback;
                end else begin
                    next_state = s_fetch;   // Branches, jmp, jpr and no-ops
                    last_state = 1'b1;
                end
            end
            s_mem: begin
                if (needs_wb) begin
                    next_state = s_writeback;
                end else begin
                    next_state = s_fetch;
                    last_state = 1'b1;
                end
            end
            s_writeback: begin
                next_state = s_fetch;
                last_state = 1'b1;
            end
            s_halted: next_state = s_halted;   // Left only through reset
            default:  next_state = s_fetch;
        endcase
    end

    assign ir_load   = (state == s_fetch);
    assign decode_en = (state == s_decode);
    assign mem_en    = (state == s_mem);
    assign wb_en     = (state == s_writeback);
    assign is_halted = (state == s_halted);

    // Halt retires in execute without moving the PC
    assign retire    = last_state | ((state == s_execute) & halt_req);
    // Taken branch redirects from execute
    assign pc_update = last_state | ((state == s_execute) & branch_taken);

endmodule

`default_nettype wire

// File: rtl/inst_counter.sv
`timescale 1ns/10ps
`default_nettype none

module inst_counter #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   retire,
    input  logic                   is_halted,
    output logic [count_width-1:0] num_inst
);

    // Wraps at full width, frozen once halted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            num_inst <= '0;
        else if (retire && !is_halted)
            num_inst <= num_inst + 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath import isa_pkg::*, ctrl_pkg::*; #(
    parameter word_t pc_reset = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  logic       ir_load,
    input  logic       pc_update,
    input  logic       mem_en,
    input  logic       wb_en,
    input  word_t      i_data,
    input  word_t      d_rdata,
    output word_t      instr,
    output word_t      i_addr,
    output word_t      d_addr,
    output word_t      d_wdata,
    output word_t      output_port,
    output logic       d_we,
    output logic       d_re,
    output logic       output_valid,
    output logic       branch_taken
);

    word_t                pc;
    word_t                pc_plus1;
    word_t                next_pc;
    word_t                ir;
    word_t                rf [0:3];
    word_t                rs_val;
    word_t                rt_val;
    word_t                imm_ext;
    word_t                alu_result;
    word_t                alu_out;   // Result of the execute cycle
    word_t                mdr;       // Load data captured in the memory cycle
    word_t                wb_data;
    reg_idx_t             rs;
    reg_idx_t             rt;
    reg_idx_t             rd;
    reg_idx_t             wb_idx;
    logic [imm_hi:imm_lo] imm;
    opcode_e              opcode;
    func_e                func;
    logic                 cond;

    assign opcode = opcode_e'(ir[opcode_hi:opcode_lo]);
    assign func   = func_e'(ir[func_hi:func_lo]);
    assign rs     = ir[rs_hi:rs_lo];
    assign rt     = ir[rt_hi:rt_lo];
    assign rd     = ir[rd_hi:rd_lo];
    assign imm    = ir[imm_hi:imm_lo];

    assign rs_val = rf[rs];
    assign rt_val = rf[rt];

    always_comb begin
        case (opcode)
            op_ori:  imm_ext = word_t'(imm);                   // Zero extended
            op_lhi:  imm_ext = {imm, 8'h00};
            default: imm_ext = {{8{imm[imm_hi]}}, imm};
        endcase
    end

    always_comb begin
        alu_result = '0;
        if (ctrl.is_alu) begin
            case (func)
                fn_add:  alu_result = rs_val + rt_val;
                fn_sub:  alu_result = rs_val - rt_val;
                fn_and:  alu_result = rs_val & rt_val;
                fn_orr:  alu_result = rs_val | rt_val;
                fn_not:  alu_result = ~rs_val;
                fn_tcp:  alu_result = ~rs_val + word_t'(1);
                fn_shl:  alu_result = {rs_val[word_size-2:0], 1'b0};
                fn_shr:  alu_result = {rs_val[word_size-1], rs_val[word_size-1:1]};   // Arithmetic
                default: alu_result = '0;
            endcase
        end else if (ctrl.alu_src) begin
            case (opcode)
                op_ori:  alu_result = rs_val | imm_ext;
                op_lhi:  alu_result = imm_ext;
                default: alu_result = rs_val + imm_ext;   // adi and memory address
            endcase
        end
    end

    // Branch compare on rs, against rt or zero
    always_comb begin
        case (opcode)
            op_bne:  cond = (rs_val != rt_val);
            op_beq:  cond = (rs_val == rt_val);
            op_bgz:  cond = !rs_val[word_size-1] && (rs_val != '0);
            op_blz:  cond = rs_val[word_size-1];
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.is_branch & cond;
    assign pc_plus1     = pc + word_t'(1);

    always_comb begin
        if (ctrl.is_jump_i)
            next_pc = {pc[word_size-1:target_hi+1], ir[target_hi:target_lo]};
        else if (ctrl.is_jump_r)
            next_pc = rs_val;
        else if (branch_taken)
            next_pc = pc_plus1 + imm_ext;
        else
            next_pc = pc_plus1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= pc_reset;
        else if (pc_update)
            pc <= next_pc;
    end

    always_ff @(posedge clk) begin
        if (ir_load)
            ir <= i_data;
        alu_out <= alu_result;
        if (d_re)
            mdr <= d_rdata;
    end

    // Writeback path
    assign wb_idx = dest_reg(ctrl, rt, rd);

    always_comb begin
        if (is_link(ctrl))
            wb_data = pc_plus1;   // Return address
        else if (ctrl.mem_to_reg)
            wb_data = mdr;
        else
            wb_data = alu_out;
    end

    always_ff @(posedge clk) begin
        if (wb_en && ctrl.reg_write)
            rf[wb_idx] <= wb_data;
    end

    assign instr        = ir;
    assign i_addr       = pc;
    assign d_addr       = alu_out;
    assign d_wdata      = rt_val;
    assign d_we         = mem_en & ctrl.mem_write;
    assign d_re         = mem_en & ctrl.mem_read;
    assign output_port  = rs_val;
    assign output_valid = wb_en & ctrl.wwd;

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top import isa_pkg::*, ctrl_pkg::*; #(
    parameter word_t pc_reset    = 16'h0000,
    parameter int    count_width = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  word_t                  i_data,
    input  word_t                  d_rdata,
    output word_t                  i_addr,
    output word_t                  d_addr,
    output word_t                  d_wdata,
    output word_t                  output_port,
    output logic                   d_we,
    output logic                   d_re,
    output logic                   output_valid,
    output logic                   is_halted,
    output logic [count_width-1:0] num_inst
);

    word_t      instr;
    ctrl_word_t ctrl;
    logic       halt_req;
    logic       decode_en;
    logic       ir_load;
    logic       pc_update;
    logic       mem_en;
    logic       wb_en;
    logic       retire;
    logic       branch_taken;

    control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .decode_en (decode_en),
        .instr     (instr),
        .ctrl      (ctrl),
        .halt_req  (halt_req)
    );

    cpu_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .halt_req     (halt_req),
        .branch_taken (branch_taken),
        .state        (),
        .ir_load      (ir_load),
        .decode_en    (decode_en),
        .pc_update    (pc_update),
        .mem_en       (mem_en),
        .wb_en        (wb_en),
        .retire       (retire),
        .is_halted    (is_halted)
    );

    inst_counter #(
        .count_width (count_width)
    ) u_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .retire    (retire),
        .is_halted (is_halted),
        .num_inst  (num_inst)
    );

    datapath #(
        .pc_reset (pc_reset)
    ) u_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .ir_load      (ir_load),
        .pc_update    (pc_update),
        .mem_en       (mem_en),
        .wb_en        (wb_en),
        .i_data       (i_data),
        .d_rdata      (d_rdata),
        .instr        (instr),
        .i_addr       (i_addr),
        .d_addr       (d_addr),
        .d_wdata      (d_wdata),
        .output_port  (output_port),
        .d_we         (d_we),
        .d_re         (d_re),
        .output_valid (output_valid),
        .branch_taken (branch_taken)
    );

endmodule

`default_nettype wire

// File: sim/cpu_sva.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_sva import ctrl_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input cpu_state_e state,
    input logic       retire,
    input logic       is_halted
);

    int fail_count = 0;   // Summed into the testbench error total

    onehot_state: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state))
        else begin
            fail_count++;
            $error("FSM state 0x%h is not one-hot", state);
        end

    no_retire_halted: assert property (@(posedge clk) disable iff (!rst_n)
                                       !(retire && state == s_halted))
        else begin
            fail_count++;
            $error("retire asserted in s_halted");
        end

    // Only reset may clear the halted level
    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) is_halted |=> is_halted)
        else begin
            fail_count++;
            $error("is_halted fell without reset");
        end

endmodule

bind cpu_fsm cpu_sva sva0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .retire    (retire),
    .is_halted (is_halted)
);

`default_nettype wire

// File: sim/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu import isa_pkg::*; ();

    localparam int count_width    = 16;
    localparam int timeout_cycles = 2000;
    localparam int halt_hold      = 50;     // Cycles watched after halt
    localparam int golden_depth   = 128;

    // Record kind, top nibble of each golden entry
    localparam logic [3:0] rec_instr = 4'h1;
    localparam logic [3:0] rec_out   = 4'h2;
    localparam logic [3:0] rec_store = 4'h3;
    localparam logic [3:0] rec_count = 4'h4;

    logic                   clk;
    logic                   rst_n;
    word_t                  i_data;
    word_t                  d_rdata;
    word_t                  i_addr;
    word_t                  d_addr;
    word_t                  d_wdata;
    word_t                  output_port;
    logic                   d_we;
    logic                   d_re;
    logic                   output_valid;
    logic                   is_halted;
    logic [count_width-1:0] num_inst;

    word_t                  imem [0:65535];
    word_t                  dmem [0:65535];
    logic [35:0]            golden [0:golden_depth-1];
    word_t                  exp_out [$];
    word_t                  exp_st_addr [$];
    word_t                  exp_st_data [$];
    logic [count_width-1:0] exp_count;
    int                     value_errors;
    int                     other_errors;

    cpu_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reads settle half a cycle before the core samples them
    always @(negedge clk) begin
        i_data  <= imem[i_addr];
        d_rdata <= dmem[d_addr];
    end

    always @(posedge clk) begin
        if (d_we)
            dmem[d_addr] <= d_wdata;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [count_width-1:0] got,
                               input logic [count_width-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // Outputs and stores are compared in program order
    always @(negedge clk) begin
        if (rst_n && output_valid) begin
            if (exp_out.size() == 0) begin
                $display("Output 0x%h at %0t was not expected", output_port, $time);
                other_errors++;
            end else begin
                check_word("output_port", output_port, exp_out.pop_front());
            end
        end
        if (rst_n && d_we) begin
            if (exp_st_addr.size() == 0) begin
                $display("Store to 0x%h at %0t was not expected", d_addr, $time);
                other_errors++;
            end else begin
                check_word("d_addr", d_addr, exp_st_addr.pop_front());
                check_word("d_wdata", d_wdata, exp_st_data.pop_front());
            end
        end
    end

    task automatic load_memories();
        int         idx;
        logic [3:0] kind;
        word_t      field_a;
        word_t      field_b;
        for (idx = 0; idx < 65536; idx++) begin
            imem[idx] = 16'hF01D;   // Halt trap outside the program
            dmem[idx] = word_t'($urandom);
        end
        for (idx = 0; idx < golden_depth; idx++)
            golden[idx] = '0;
        exp_count = '0;
        $readmemh("sim/cpu_golden.hex", golden);
        for (idx = 0; idx < golden_depth; idx++) begin
            {kind, field_a, field_b} = golden[idx];
            case (kind)
                rec_instr: imem[field_a] = field_b;
                rec_out:   exp_out.push_back(field_b);
                rec_store: begin
                    exp_st_addr.push_back(field_a);
                    exp_st_data.push_back(field_b);
                end
                rec_count: exp_count = field_b;
                default:   ;
            endcase
        end
    endtask

    task automatic wait_for_halt(output logic ok);
        int cycles;
        cycles = 0;
        while (!is_halted && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        ok = is_halted;
        if (!ok) begin
            $display("Timeout: the core did not halt within %0d cycles", timeout_cycles);
            other_errors++;
        end
    endtask

    task automatic check_halt_hold();
        logic [count_width-1:0] count_at_halt;
        count_at_halt = num_inst;
        check_count("num_inst", num_inst, exp_count);   // Halt itself is counted
        repeat (halt_hold) begin
            @(negedge clk);
            check_flag("is_halted", is_halted, 1'b1);
            check_flag("output_valid", output_valid, 1'b0);
            check_flag("d_we", d_we, 1'b0);
            check_flag("d_re", d_re, 1'b0);
            check_count("num_inst", num_inst, count_at_halt);
        end
        if (exp_out.size() != 0) begin
            $display("%0d expected outputs never appeared", exp_out.size());
            other_errors++;
        end
        if (exp_st_addr.size() != 0) begin
            $display("%0d expected stores never happened", exp_st_addr.size());
            other_errors++;
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = dut0.u_fsm.sva0.fail_count;
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    initial begin
        logic halted_ok;
        rst_n        = 1'b0;
        i_data       = '0;
        d_rdata      = '0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(32'h5471eb73));
        load_memories();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_flag("is_halted", is_halted, 1'b0);
        check_flag("d_we", d_we, 1'b0);
        check_flag("d_re", d_re, 1'b0);
        check_flag("output_valid", output_valid, 1'b0);
        check_count("num_inst", num_inst, '0);
        check_word("i_addr", i_addr, 16'h0000);
        rst_n <= 1'b1;
        wait_for_halt(halted_ok);
        if (halted_ok)
            check_halt_hold();
        finish_run();
    end

endmodule

`default_nettype wire

// File: sim/cpu_golden.hex
// Each word is a record kind digit, then fields a and b of four hex digits
// Kind 1 instr addr, word / 2 output (b) / 3 store addr, data / 4 instruction count (b)
100006012 100015034 10002F01C 200001234  // lhi r0, ori r0, wwd r0
1000341FF 10004F1C0 10005FC1C 200002467  // adi r1 = -1, add r3, wwd r3
10006F4C1 10007FC1C 20000FFFF            // sub
10008F1C2 10009FC1C 200001230            // and
1000AF1C3 1000BFC1C 200001237            // or
1000CF0C4 1000DFC1C 20000EDCB            // not
1000EF0C5 1000FFC1C 20000EDCC            // two's complement
10010FCC6 10011FC1C 20000DB98            // shift left
10012FCC7 10013FC1C 20000EDCC            // shift right keeps the sign
100148110 312441233                      // swd r1 to 0x1244
100157310 10016FC1C 200001233            // lwd r3 back, wwd r3
100170101 10018F01C                      // bne taken over a trap
100191101 1001AF41C 200001233            // beq not taken, wwd r1
1001B2401 1001CF01C 1001D3C01            // bgz taken over a trap, blz not taken
1001EA022 10022F819 1001FF81C 20000001F  // jal 0x22, jpr back, wwd link
100209024 100246300 100254F28            // jmp 0x24, r3 = 0x0028
10026FC1A 10028F81C 200000027            // jrl r3, wwd link
10029FCC5 1002A3C01 1002BF01C            // tcp r3, blz taken over a trap
1002C1001 1002DF01C                      // beq taken over a trap
1002EFC1C 20000FFD8 1002FF01D            // wwd r3, hlt
400000029                                // 41 retired with the hlt

// File: project.f
common/isa_pkg.sv
common/ctrl_pkg.sv
control/control.sv
control/cpu_fsm.sv
rtl/inst_counter.sv
rtl/datapath.sv
rtl/cpu_top.sv
sim/cpu_sva.sv
sim/tb_cpu.sv

// File: Makefile
# Verilator build and run for the multi-cycle CPU testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_LINE := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qxF '$(PASS_LINE)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
